// File: project.f
src/uart_line_pkg.sv
src/uart_cmd_pkg.sv
src/uart_tx_frame.sv
src/uart_rx_frame.sv
src/uart_cmd_ctrl.sv
src/uart_cmd_top.sv
tests/uart_reg_slave.sv
tests/tb_uart_cmd.sv

// File: Makefile
SIM       = verilator
SIM_FLAGS = --binary --timing --assert -j 0
TOP       = tb_uart_cmd
FILE_LIST = project.f

.PHONY: sim clean

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir

// File: tests/tb_uart_cmd.sv
`timescale 1ns/10ps

module tb_uart_cmd;

  import uart_line_pkg::*;
  import uart_cmd_pkg::*;

  localparam int bit_clks   = 16;
  localparam int write_clks = 24 * bit_clks + 3;
  // forty commands of at most thirty bit times, the reset and some slack.
  localparam int max_cycles = 16 + 40 * 30 * bit_clks + 2000;

  logic                 clk;
  logic                 rst_n;
  logic [cmd_width-1:0] cmd_in;
  logic                 cmd_vld;
  logic                 rx;
  logic                 tx;
  logic                 cmd_rdy;
  logic [byte_bits-1:0] read_data;
  logic                 read_rdy;
  logic                 parity_err;
  logic                 corrupt_parity;
  int                   frame_count;
  int                   frame_errors;
  int                   err_cnt;
  int                   cycle = 0;
  logic [byte_bits-1:0] shadow [128];
  logic [byte_bits-1:0] snap [128];
  bit                   written [128];

  uart_cmd_top #(
    .clks_per_bit(bit_clks)
  ) u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .tx        (tx),
    .cmd_rdy   (cmd_rdy),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .parity_err(parity_err)
  );

  uart_reg_slave #(
    .clks_per_bit(bit_clks)
  ) u_slave (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx_line       (tx),
    .corrupt_parity(corrupt_parity),
    .tx_line       (rx),
    .frame_count   (frame_count),
    .frame_errors  (frame_errors)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= max_cycles) begin
      $display("run stopped after %0d cycles with commands still pending", cycle);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic report_mismatch(input string name, input int expected, input int actual);
    err_cnt++;
    $display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
  endtask

  task automatic report_failure(input string msg);
    err_cnt++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  a_rdy_on_reply: assert property (@(posedge clk) disable iff (!rst_n) read_rdy |-> cmd_rdy)
    else report_mismatch("cmd_rdy", 1, 0);
  a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy)
    else report_mismatch("read_rdy", 0, 1);
  a_line_idle: assert property (@(posedge clk) disable iff (!rst_n) cmd_rdy |-> tx == stop_level)
    else report_mismatch("tx", 1, 0);
  a_data_hold: assert property (@(posedge clk) disable iff (!rst_n)
      read_data != $past(read_data) |-> read_rdy)
    else report_failure("read_data changed outside a read_rdy pulse");
  a_perr_hold: assert property (@(posedge clk) disable iff (!rst_n)
      parity_err != $past(parity_err) |-> read_rdy)
    else report_failure("parity_err changed outside a read_rdy pulse");

  task automatic check_reset_outputs();
    assert (tx == stop_level) else report_mismatch("tx", 1, int'(tx));
    assert (cmd_rdy) else report_mismatch("cmd_rdy", 1, int'(cmd_rdy));
    assert (!read_rdy) else report_mismatch("read_rdy", 0, int'(read_rdy));
    assert (!parity_err) else report_mismatch("parity_err", 0, int'(parity_err));
    assert (read_data == '0) else report_mismatch("read_data", 0, int'(read_data));
  endtask

  task automatic take_snapshot();
    for (int i = 0; i < 128; i++) begin
      snap[i] = u_slave.regs[i];
    end
  endtask

  task automatic compare_memory();
    for (int i = 0; i < 128; i++) begin
      assert (u_slave.regs[i] == snap[i])
        else report_mismatch($sformatf("slave regs[%0d]", i), int'(snap[i]),
                             int'(u_slave.regs[i]));
    end
  endtask

  // a command offered while busy must leave no trace.
  task automatic poke_busy(input logic poke);
    if (poke && !cmd_rdy && $urandom_range(0, 3) == 0) begin
      cmd_in  = 16'($urandom);
      cmd_vld = 1'b1;
    end else begin
      cmd_vld = 1'b0;
    end
  endtask

  task automatic do_write(input logic [addr_width-1:0] addr, input logic [byte_bits-1:0] data,
                          input logic poke);
    int t0;
    int n0;
    n0 = frame_count;
    take_snapshot();
    cmd_in  = {1'b1, addr, data};
    cmd_vld = 1'b1;
    @(negedge clk);
    t0      = cycle;
    cmd_vld = 1'b0;
    assert (!cmd_rdy) else report_failure("cmd_rdy stayed high after a write was taken");
    shadow[addr]  = data;
    written[addr] = 1'b1;
    snap[addr]    = data;
    while (!cmd_rdy) begin
      poke_busy(poke);
      @(negedge clk);
    end
    cmd_vld = 1'b0;
    assert (cycle - t0 == write_clks) else report_mismatch("cmd_rdy delay", write_clks, cycle - t0);
    assert (frame_count == n0 + 2) else report_mismatch("frame_count", n0 + 2, frame_count);
    assert (u_slave.regs[addr] == shadow[addr])
      else report_mismatch("slave write data", int'(shadow[addr]), int'(u_slave.regs[addr]));
    compare_memory();
  endtask

  task automatic do_read(input logic [addr_width-1:0] addr, input logic bad_parity,
                         input logic poke);
    logic [byte_bits-1:0] expected;
    int                   n0;
    n0       = frame_count;
    take_snapshot();
    expected = written[addr] ? shadow[addr] : u_slave.regs[addr];
    corrupt_parity = bad_parity;
    cmd_in  = {1'b0, addr, 8'($urandom)};
    cmd_vld = 1'b1;
    @(negedge clk);
    cmd_vld = 1'b0;
    while (!read_rdy) begin
      assert (!cmd_rdy) else report_failure("cmd_rdy rose before the read reply arrived");
      poke_busy(poke);
      @(negedge clk);
    end
    cmd_vld        = 1'b0;
    corrupt_parity = 1'b0;
    assert (read_data == expected)
      else report_mismatch("read_data", int'(expected), int'(read_data));
    assert (parity_err == bad_parity)
      else report_mismatch("parity_err", int'(bad_parity), int'(parity_err));
    assert (frame_count == n0 + 1) else report_mismatch("frame_count", n0 + 1, frame_count);
    compare_memory();
  endtask

  initial begin
    logic [addr_width-1:0] addr;
    void'($urandom(32'h7ae8));
    rst_n          = 1'b0;
    cmd_in         = '0;
    cmd_vld        = 1'b0;
    corrupt_parity = 1'b0;
    err_cnt        = 0;
    for (int i = 0; i < 128; i++) begin
      written[i] = 1'b0;
    end
    repeat (16) begin
      @(negedge clk);
      check_reset_outputs();
    end
    rst_n = 1'b1;
    @(negedge clk);
    check_reset_outputs();

    do_write(7'h00, 8'h3c, 1'b0);
    do_write(7'h7f, 8'hc3, 1'b0);
    do_write(7'h2a, 8'h96, 1'b0);
    do_read(7'h00, 1'b0, 1'b0);
    do_read(7'h7f, 1'b0, 1'b0);
    do_read(7'h2a, 1'b0, 1'b0);
    do_read(7'h2a, 1'b1, 1'b0);   // flipped check bit on the reply.
    do_read(7'h7f, 1'b0, 1'b0);
    do_write(7'h15, 8'h5e, 1'b1);
    do_read(7'h15, 1'b0, 1'b1);

    for (int n = 0; n < 30; n++) begin
      repeat ($urandom_range(0, 20)) @(negedge clk);
      addr = 7'($urandom_range(0, 127));
      if ($urandom_range(0, 1) == 1) begin
        do_write(addr, 8'($urandom), 1'b0);
      end else begin
        do_read(addr, 1'b0, 1'b0);
      end
    end

    repeat (4) @(negedge clk);
    $display("finished: %0d failed checks, %0d slave frame errors", err_cnt, frame_errors);
    if (err_cnt == 0 && frame_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: tests/uart_reg_slave.sv
`timescale 1ns/10ps

module uart_reg_slave #(
  parameter int clks_per_bit = 16
) (
  input  logic clk,
  input  logic rst_n,
  input  logic rx_line,
  input  logic corrupt_parity,
  output logic tx_line,
  output int   frame_count,
  output int   frame_errors
);

  import uart_line_pkg::*;

  logic [byte_bits-1:0] regs [128];
  logic [6:0]           reply_addr;
  event                 reply_ev;

  // all line activity of the slave lines up with falling clock edges.
  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // decodes one frame, sampling every bit near its middle.
  task automatic get_frame(output logic [byte_bits-1:0] data);
    logic par;
    @(negedge rx_line);
    wait_cycles(clks_per_bit / 2);
    if (rx_line !== start_level) begin
      $display("slave: start bit near %0t went back high", $time);
      frame_errors++;
    end
    for (int i = 0; i < byte_bits; i++) begin
      wait_cycles(clks_per_bit);
      data[i] = rx_line;
    end
    wait_cycles(clks_per_bit);
    par = rx_line;
    wait_cycles(clks_per_bit);
    if (par !== ^data) begin
      $display("slave: frame ending at %0t carries a wrong check bit", $time);
      frame_errors++;
    end
    if (rx_line !== stop_level) begin
      $display("slave: frame ending at %0t has no stop bit", $time);
      frame_errors++;
    end
    frame_count++;
  endtask

  task automatic send_frame(input logic [byte_bits-1:0] data);
    logic [byte_bits+2:0] bits;
    bits = {stop_level, (^data) ^ corrupt_parity, data, start_level};
    for (int i = 0; i < byte_bits + 3; i++) begin
      tx_line = bits[i];
      wait_cycles(clks_per_bit);
    end
  endtask

  initial begin
    logic [byte_bits-1:0] cmd_byte;
    logic [byte_bits-1:0] data_byte;
    for (int i = 0; i < 128; i++) begin
      regs[i] = byte_bits'(i * 37 + 11);   // odd step, so every address bit counts.
    end
    frame_count  = 0;
    frame_errors = 0;
    wait (rst_n === 1'b1);
    forever begin
      get_frame(cmd_byte);
      if (cmd_byte[byte_bits-1]) begin
        get_frame(data_byte);
        regs[cmd_byte[6:0]] = data_byte;
      end else begin
        reply_addr = cmd_byte[6:0];
        -> reply_ev;
      end
    end
  end

  // the reply runs on its own so the receiver never misses the next start bit.
  initial begin
    tx_line = stop_level;
    forever begin
      @(reply_ev);
      wait_cycles(3 * clks_per_bit);
      send_frame(regs[reply_addr]);
    end
  end

endmodule

// File: src/uart_cmd_top.sv
`timescale 1ns/10ps

module uart_cmd_top #(
  parameter int clks_per_bit = 434
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [uart_cmd_pkg::cmd_width-1:0]  cmd_in,
  input  logic                                cmd_vld,
  input  logic                                rx,
  output logic                                tx,
  output logic                                cmd_rdy,
  output logic [uart_line_pkg::byte_bits-1:0] read_data,
  output logic                                read_rdy,
  output logic                                parity_err
);

  import uart_line_pkg::*;

  logic                 tx_start;
  logic                 tx_busy;
  logic [byte_bits-1:0] tx_byte;
  logic [byte_bits-1:0] rx_byte;
  logic                 rx_parity_bad;
  logic                 rx_done;

  uart_cmd_ctrl #(
    .clks_per_bit(clks_per_bit)
  ) u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_in       (cmd_in),
    .cmd_vld      (cmd_vld),
    .tx_busy      (tx_busy),
    .rx_byte      (rx_byte),
    .rx_parity_bad(rx_parity_bad),
    .rx_done      (rx_done),
    .cmd_rdy      (cmd_rdy),
    .tx_start     (tx_start),
    .tx_byte      (tx_byte),
    .read_data    (read_data),
    .read_rdy     (read_rdy),
    .parity_err   (parity_err)
  );

  uart_tx_frame #(
    .clks_per_bit(clks_per_bit)
  ) u_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_start(tx_start),
    .tx_byte (tx_byte),
    .tx      (tx),
    .tx_busy (tx_busy)
  );

  // the receiver listens all the time and the controller picks what it needs.
  uart_rx_frame #(
    .clks_per_bit(clks_per_bit)
  ) u_rx (
    .clk          (clk),
    .rst_n        (rst_n),
    .rx           (rx),
    .rx_byte      (rx_byte),
    .rx_parity_bad(rx_parity_bad),
    .rx_done      (rx_done)
  );

endmodule

// File: src/uart_cmd_ctrl.sv
`timescale 1ns/10ps

module uart_cmd_ctrl #(
  parameter int clks_per_bit = 434
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [uart_cmd_pkg::cmd_width-1:0]  cmd_in,
  input  logic                                cmd_vld,
  input  logic                                tx_busy,
  input  logic [uart_line_pkg::byte_bits-1:0] rx_byte,
  input  logic                                rx_parity_bad,
  input  logic                                rx_done,
  output logic                                cmd_rdy,
  output logic                                tx_start,
  output logic [uart_line_pkg::byte_bits-1:0] tx_byte,
  output logic [uart_line_pkg::byte_bits-1:0] read_data,
  output logic                                read_rdy,
  output logic                                parity_err
);

  import uart_line_pkg::*;
  import uart_cmd_pkg::*;

  localparam int gap_len = gap_bits * clks_per_bit;
  localparam int gap_w   = (gap_len > 1) ? $clog2(gap_len) : 1;

  cmd_state_t           state;
  logic [gap_w-1:0]     gap_cnt;
  logic                 is_write;
  logic [byte_bits-1:0] wr_data;
  logic                 accept;
  logic                 frame_done;
  logic                 gap_done;

  // deliver shows the reply and is ready for the next command at once.
  assign cmd_rdy  = (state == idle) || (state == deliver);
  assign read_rdy = (state == deliver);
  assign accept   = cmd_rdy && cmd_vld;

  // tx_busy only rises a cycle after tx_start, so a pending start still counts as busy.
  assign frame_done = !tx_start && !tx_busy;

  // the tx_start register adds one idle cycle, so the count stops one short.
  assign gap_done = (gap_cnt == gap_w'(gap_len - 2));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= idle;
      tx_start   <= 1'b0;
      gap_cnt    <= '0;
      is_write   <= 1'b0;
      read_data  <= '0;
      parity_err <= 1'b0;
    end else begin
      tx_start <= 1'b0;
      case (state)
        idle, deliver: begin
          if (accept) begin
            state    <= send_cmd;
            tx_start <= 1'b1;
            is_write <= cmd_in[write_flag_bit];
          end else begin
            state <= idle;
          end
        end
        send_cmd: begin
          if (frame_done) begin
            gap_cnt <= '0;
            state   <= is_write ? gap : wait_reply;
          end
        end
        gap: begin
          if (gap_done) begin
            state    <= send_data;
            tx_start <= 1'b1;
          end else begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        send_data: begin
          if (frame_done) begin
            state <= idle;
          end
        end
        wait_reply: begin
          // rx_done is ignored in every other state.
          if (rx_done) begin
            state      <= deliver;
            read_data  <= rx_byte;
            parity_err <= rx_parity_bad;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // command byte is the write flag over the address, data byte follows for writes.
  always_ff @(posedge clk) begin
    if (accept) begin
      tx_byte <= {cmd_in[write_flag_bit], cmd_in[write_flag_bit-1 -: addr_width]};
      wr_data <= cmd_in[byte_bits-1:0];
    end else if (state == gap && gap_done) begin
      tx_byte <= wr_data;
    end
  end

endmodule

// File: src/uart_rx_frame.sv
`timescale 1ns/10ps

module uart_rx_frame #(
  parameter int clks_per_bit = 434
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                rx,
  output logic [uart_line_pkg::byte_bits-1:0] rx_byte,
  output logic                                rx_parity_bad,
  output logic                                rx_done
);

  import uart_line_pkg::*;

  localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
  localparam int half  = clks_per_bit / 2;
  localparam int idx_w = $clog2(byte_bits + 1);

  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_bits,
    rx_stop
  } rx_state_t;

  rx_state_t            state;
  logic                 rx_meta;
  logic                 rx_sync;
  logic                 rx_prev;
  logic [cnt_w-1:0]     clk_cnt;
  logic [idx_w-1:0]     bit_idx;    // data bits first, then the check bit.
  logic [byte_bits-1:0] data_q;
  logic                 par_q;
  logic                 mid_start;
  logic                 bit_end;

  assign mid_start = (clk_cnt == cnt_w'(half - 1));
  assign bit_end   = (clk_cnt == cnt_w'(clks_per_bit - 1));

  // two flops bring the line into the clock domain.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= idle_level;
      rx_sync <= idle_level;
      rx_prev <= idle_level;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= rx_idle;
      clk_cnt <= '0;
      bit_idx <= '0;
      rx_done <= 1'b0;
    end else begin
      rx_done <= 1'b0;
      case (state)
        rx_idle: begin
          clk_cnt <= '0;
          if (rx_prev == idle_level && rx_sync == start_level) begin
            state <= rx_start;
          end
        end
        rx_start: begin
          if (mid_start) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            // a line that is back high here was only a glitch.
            state   <= (rx_sync == start_level) ? rx_bits : rx_idle;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        rx_bits: begin
          if (bit_end) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == idx_w'(byte_bits)) begin
              state <= rx_stop;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        rx_stop: begin
          if (bit_end) begin
            clk_cnt <= '0;
            rx_done <= 1'b1;              // middle of the stop bit.
            state   <= rx_idle;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

  // sampled bits and the finished byte.
  always_ff @(posedge clk) begin
    if (state == rx_bits && bit_end) begin
      if (bit_idx < idx_w'(byte_bits)) begin
        data_q <= {rx_sync, data_q[byte_bits-1:1]};   // lsb arrives first.
      end else begin
        par_q <= rx_sync;
      end
    end
    if (state == rx_stop && bit_end) begin
      rx_byte       <= data_q;
      rx_parity_bad <= (par_q != even_parity(data_q));
    end
  end

endmodule

// File: src/uart_tx_frame.sv
`timescale 1ns/10ps

module uart_tx_frame #(
  parameter int clks_per_bit = 434
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                tx_start,
  input  logic [uart_line_pkg::byte_bits-1:0] tx_byte,
  output logic                                tx,
  output logic                                tx_busy
);

  import uart_line_pkg::*;

  localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
  localparam int idx_w = $clog2(frame_bits);

  logic [cnt_w-1:0]     clk_cnt;
  logic [idx_w-1:0]     bit_idx;   // 0 is the start bit, frame_bits-1 the stop bit.
  logic [byte_bits+1:0] shift_q;   // data, check bit and stop still to be sent.
  logic                 bit_end;
  logic                 load;

  assign bit_end = (clk_cnt == cnt_w'(clks_per_bit - 1));
  assign load    = tx_start && !tx_busy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx      <= idle_level;
      tx_busy <= 1'b0;
      clk_cnt <= '0;
      bit_idx <= '0;
    end else if (!tx_busy) begin
      if (tx_start) begin
        tx      <= start_level;       // start bit goes out right away.
        tx_busy <= 1'b1;
        clk_cnt <= '0;
        bit_idx <= '0;
      end
    end else if (bit_end) begin
      clk_cnt <= '0;
      if (bit_idx == idx_w'(frame_bits - 1)) begin
        // the stop bit has run its full period and the line stays high.
        tx_busy <= 1'b0;
      end else begin
        tx      <= shift_q[0];
        bit_idx <= bit_idx + 1'b1;
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  // the frame tail is built once when the byte is latched.
  always_ff @(posedge clk) begin
    if (load) begin
      shift_q <= {stop_level, even_parity(tx_byte), tx_byte};
    end else if (tx_busy && bit_end) begin
      shift_q <= {idle_level, shift_q[byte_bits+1:1]};
    end
  end

endmodule

// File: src/uart_cmd_pkg.sv
package uart_cmd_pkg;

  // host command word.
  localparam int cmd_width = 16;

  // bit 15 set means write, clear means read.
  localparam int write_flag_bit = 15;

  // register address sits right below the write flag.
  localparam int addr_width = 7;

  // idle bit times between the command and data frames of a write.
  localparam int gap_bits = 2;

  // controller states.
  // deliver presents a read reply for one cycle and already takes
  // the next command.
  typedef enum logic [2:0] {
    idle,
    send_cmd,
    gap,
    send_data,
    wait_reply,
    deliver
  } cmd_state_t;

endpackage

// File: src/uart_line_pkg.sv
package uart_line_pkg;

  // data bits carried by one serial frame.
  localparam int byte_bits = 8;

  // levels seen on the line for the start and stop bits.
  localparam logic start_level = 1'b0;
  localparam logic stop_level  = 1'b1;

  // the line rests at the stop level between frames.
  localparam logic idle_level = stop_level;

  // each frame is start, data, check bit and stop.
  localparam int frame_bits = byte_bits + 3;

  // the check bit makes the count of ones in data plus check even.
  function automatic logic even_parity(input logic [byte_bits-1:0] data);
    logic par;
    par = 1'b0;
    for (int i = 0; i < byte_bits; i++) begin
      par = par ^ data[i];
    end
    return par;
  endfunction

endpackage
